// File: mips_params.svh
////////////////////////////////////////////////////////////
// MIPS pipeline constants: widths, memory depths and the
// opcode and funct encodings of the supported instructions
////////////////////////////////////////////////////////////
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

`define MIPS_WORD_W       32
`define MIPS_REG_ADDR_W   5

`define MIPS_IMEM_DEPTH   64
`define MIPS_IMEM_ADDR_W  6
`define MIPS_DMEM_DEPTH   64
`define MIPS_DMEM_ADDR_W  6

// opcodes
`define MIPS_OP_RTYPE     6'h00
`define MIPS_OP_ADDI      6'h08
`define MIPS_OP_LW        6'h23
`define MIPS_OP_SW        6'h2B

// R-type funct field
`define MIPS_FN_ADD       6'h20
`define MIPS_FN_SUB       6'h22
`define MIPS_FN_AND       6'h24
`define MIPS_FN_OR        6'h25
`define MIPS_FN_SLT       6'h2A

`endif

// File: mips_pkg.sv
////////////////////////////////////////////////////////////
// MIPS pipeline types for the instruction word views and
// the ALU operations
////////////////////////////////////////////////////////////
`default_nettype none

`include "mips_params.svh"

package mips_pkg;

    typedef struct packed {
        logic [5:0]                  opcode;
        logic [`MIPS_REG_ADDR_W-1:0] rs;
        logic [`MIPS_REG_ADDR_W-1:0] rt;
        logic [`MIPS_REG_ADDR_W-1:0] rd;
        logic [4:0]                  shamt;
        logic [5:0]                  funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]                  opcode;
        logic [`MIPS_REG_ADDR_W-1:0] rs;
        logic [`MIPS_REG_ADDR_W-1:0] rt;
        logic [15:0]                 imm;
    } i_fields_t;

    // one word read as R or I view by opcode
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_NONE    // no result, nothing retires
    } alu_op_t;

endpackage

`default_nettype wire

// File: instr_fetch.sv
////////////////////////////////////////////////////////////
// Fetch: program counter, instruction memory and its
// load port used while the core is held in reset
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module instr_fetch (
    input  wire                           SYS_clk,
    input  wire                           SYS_reset,
    input  wire                           stall,
    input  wire                           imem_load_en,
    input  wire [`MIPS_IMEM_ADDR_W-1:0]   imem_load_addr,
    input  wire [`MIPS_WORD_W-1:0]        imem_load_data,
    output mips_pkg::instr_t              fetch_instr
);
    localparam int PC_W = `MIPS_IMEM_ADDR_W + 2;     // byte address

    logic [`MIPS_WORD_W-1:0] imem [`MIPS_IMEM_DEPTH];
    logic [PC_W-1:0]         pc;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            pc <= '0;
        else if (!stall)
            pc <= pc + PC_W'(4);                     // next word
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset && imem_load_en)
            imem[imem_load_addr] <= imem_load_data;  // program load
    end

    assign fetch_instr = imem[pc[PC_W-1:2]];         // decode register samples this

    // program may only be loaded while the core is held
    a_load_in_reset: assert property (@(posedge SYS_clk) imem_load_en |-> SYS_reset);

endmodule

`default_nettype wire

// File: hazard_unit.sv
////////////////////////////////////////////////////////////
// Hazard detection: stall on execute or load distance,
// forward select from the memory stage into decode
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module hazard_unit (
    input  wire mips_pkg::instr_t           dec_instr,
    input  wire [`MIPS_REG_ADDR_W-1:0]      ex_dest,
    input  wire [`MIPS_REG_ADDR_W-1:0]      mem_dest,
    input  wire                             ex_reg_write,
    input  wire                             mem_reg_write,
    input  wire                             mem_mem_read,
    output logic                            stall,
    output logic                            fwd_rs,
    output logic                            fwd_rt
);
    logic [5:0] opcode;
    logic       reads_rs;
    logic       reads_rt;
    logic       ex_rs_hit;
    logic       ex_rt_hit;
    logic       mem_rs_hit;
    logic       mem_rt_hit;

    function automatic logic hit(input logic                        wr,
                                 input logic [`MIPS_REG_ADDR_W-1:0] dest,
                                 input logic [`MIPS_REG_ADDR_W-1:0] src);
        return wr && (dest != '0) && (dest == src);
    endfunction

    assign opcode   = dec_instr.r.opcode;
    assign reads_rs = opcode inside {`MIPS_OP_RTYPE, `MIPS_OP_ADDI, `MIPS_OP_LW, `MIPS_OP_SW};
    assign reads_rt = opcode inside {`MIPS_OP_RTYPE, `MIPS_OP_SW};   // sw stores rt

    assign ex_rs_hit  = reads_rs && hit(ex_reg_write, ex_dest, dec_instr.r.rs);
    assign ex_rt_hit  = reads_rt && hit(ex_reg_write, ex_dest, dec_instr.r.rt);
    assign mem_rs_hit = reads_rs && hit(mem_reg_write, mem_dest, dec_instr.r.rs);
    assign mem_rt_hit = reads_rt && hit(mem_reg_write, mem_dest, dec_instr.r.rt);

    // load data is not ready until write-back
    assign stall = ex_rs_hit || ex_rt_hit || (mem_mem_read && (mem_rs_hit || mem_rt_hit));

    assign fwd_rs = mem_rs_hit && !mem_mem_read;     // ALU result only
    assign fwd_rt = mem_rt_hit && !mem_mem_read;

endmodule

`default_nettype wire

// File: decode_stage.sv
////////////////////////////////////////////////////////////
// Decode stage with the instruction register, control decode,
// register file with write-through and the memory forward muxes
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module decode_stage (
    input  wire                             SYS_clk,
    input  wire                             SYS_reset,
    input  wire                             stall,
    input  wire mips_pkg::instr_t           fetch_instr,
    input  wire                             fwd_rs,
    input  wire                             fwd_rt,
    input  wire [`MIPS_WORD_W-1:0]          mem_alu_result,
    input  wire                             wb_we,
    input  wire [`MIPS_REG_ADDR_W-1:0]      wb_dest,
    input  wire [`MIPS_WORD_W-1:0]          wb_data,
    input  wire [`MIPS_REG_ADDR_W-1:0]      reg_sel,
    output logic [`MIPS_WORD_W-1:0]         reg_value,
    output mips_pkg::instr_t                dec_instr,
    output logic [`MIPS_WORD_W-1:0]         dec_rs_val,
    output logic [`MIPS_WORD_W-1:0]         dec_rt_val,
    output logic [`MIPS_WORD_W-1:0]         dec_imm,
    output logic [`MIPS_REG_ADDR_W-1:0]     dec_dest,
    output mips_pkg::alu_op_t               dec_alu_op,
    output logic                            dec_use_imm,
    output logic                            dec_reg_write,
    output logic                            dec_mem_read,
    output logic                            dec_mem_write
);
    import mips_pkg::*;

    logic [`MIPS_WORD_W-1:0] regs [2**`MIPS_REG_ADDR_W];

    // r0 is hardwired and write-back bypasses the array
    function automatic logic [`MIPS_WORD_W-1:0] rf_read(input logic [`MIPS_REG_ADDR_W-1:0] idx);
        if (idx == '0)
            return '0;
        else if (wb_we && (wb_dest == idx))
            return wb_data;
        else
            return regs[idx];
    endfunction

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            dec_instr <= '0;                         // nop
        else if (!stall)
            dec_instr <= fetch_instr;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (wb_we)
            regs[wb_dest] <= wb_data;
    end

    always_comb
    begin
        dec_rs_val = fwd_rs ? mem_alu_result : rf_read(dec_instr.r.rs);
        dec_rt_val = fwd_rt ? mem_alu_result : rf_read(dec_instr.r.rt);
        reg_value  = rf_read(reg_sel);               // inspection port
    end

    assign dec_imm = {{(`MIPS_WORD_W-16){dec_instr.i.imm[15]}}, dec_instr.i.imm};

    always_comb
    begin
        dec_alu_op    = ALU_NONE;
        dec_use_imm   = 1'b0;
        dec_reg_write = 1'b0;
        dec_mem_read  = 1'b0;
        dec_mem_write = 1'b0;
        dec_dest      = dec_instr.i.rt;              // I-type writes rt
        case (dec_instr.r.opcode)
            `MIPS_OP_RTYPE:
            begin
                dec_dest = dec_instr.r.rd;
                case (dec_instr.r.funct)
                    `MIPS_FN_ADD: dec_alu_op = ALU_ADD;
                    `MIPS_FN_SUB: dec_alu_op = ALU_SUB;
                    `MIPS_FN_AND: dec_alu_op = ALU_AND;
                    `MIPS_FN_OR:  dec_alu_op = ALU_OR;
                    `MIPS_FN_SLT: dec_alu_op = ALU_SLT;
                    default:      dec_alu_op = ALU_NONE;
                endcase
                dec_reg_write = (dec_alu_op != ALU_NONE);
            end
            `MIPS_OP_ADDI:
            begin
                dec_alu_op    = ALU_ADD;
                dec_use_imm   = 1'b1;
                dec_reg_write = 1'b1;
            end
            `MIPS_OP_LW:
            begin
                dec_alu_op    = ALU_ADD;             // base + offset
                dec_use_imm   = 1'b1;
                dec_reg_write = 1'b1;
                dec_mem_read  = 1'b1;
            end
            `MIPS_OP_SW:
            begin
                dec_alu_op    = ALU_ADD;
                dec_use_imm   = 1'b1;
                dec_mem_write = 1'b1;
            end
            default:
                dec_alu_op = ALU_NONE;               // retires without effect
        endcase
        if (dec_dest == '0)
            dec_reg_write = 1'b0;                    // writes to r0 are dropped here
    end

    // nothing down the pipe may target r0
    a_no_r0_write: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !(wb_we && (wb_dest == '0)));

endmodule

`default_nettype wire

// File: execute_stage.sv
////////////////////////////////////////////////////////////
// Execute: pipeline register with bubble insert on stall,
// operand select and the ALU
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module execute_stage (
    input  wire                             SYS_clk,
    input  wire                             SYS_reset,
    input  wire                             stall,
    input  wire mips_pkg::instr_t           dec_instr,
    input  wire [`MIPS_WORD_W-1:0]          dec_rs_val,
    input  wire [`MIPS_WORD_W-1:0]          dec_rt_val,
    input  wire [`MIPS_WORD_W-1:0]          dec_imm,
    input  wire [`MIPS_REG_ADDR_W-1:0]      dec_dest,
    input  wire mips_pkg::alu_op_t          dec_alu_op,
    input  wire                             dec_use_imm,
    input  wire                             dec_reg_write,
    input  wire                             dec_mem_read,
    input  wire                             dec_mem_write,
    output mips_pkg::instr_t                ex_instr,
    output logic [`MIPS_REG_ADDR_W-1:0]     ex_dest,
    output logic                            ex_reg_write,
    output logic                            ex_mem_read,
    output logic                            ex_mem_write,
    output logic [`MIPS_WORD_W-1:0]         ex_result,
    output logic [`MIPS_WORD_W-1:0]         ex_store_data
);
    import mips_pkg::*;

    alu_op_t                 ex_alu_op;
    logic                    ex_use_imm;
    logic [`MIPS_WORD_W-1:0] ex_rs_val;
    logic [`MIPS_WORD_W-1:0] ex_rt_val;
    logic [`MIPS_WORD_W-1:0] ex_imm;
    logic [`MIPS_WORD_W-1:0] alu_b;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || stall)
        begin
            ex_instr     <= '0;                      // bubble
            ex_dest      <= '0;
            ex_alu_op    <= ALU_NONE;
            ex_use_imm   <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
        end
        else
        begin
            ex_instr     <= dec_instr;
            ex_dest      <= dec_dest;
            ex_alu_op    <= dec_alu_op;
            ex_use_imm   <= dec_use_imm;
            ex_reg_write <= dec_reg_write;
            ex_mem_read  <= dec_mem_read;
            ex_mem_write <= dec_mem_write;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        ex_rs_val <= dec_rs_val;
        ex_rt_val <= dec_rt_val;
        ex_imm    <= dec_imm;
    end

    assign alu_b         = ex_use_imm ? ex_imm : ex_rt_val;
    assign ex_store_data = ex_rt_val;                // sw data

    always_comb
    begin
        case (ex_alu_op)
            ALU_ADD: ex_result = ex_rs_val + alu_b;  // wraps
            ALU_SUB: ex_result = ex_rs_val - alu_b;
            ALU_AND: ex_result = ex_rs_val & alu_b;
            ALU_OR:  ex_result = ex_rs_val | alu_b;
            ALU_SLT: ex_result = {{(`MIPS_WORD_W-1){1'b0}}, $signed(ex_rs_val) < $signed(alu_b)};
            default: ex_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: memory_writeback.sv
////////////////////////////////////////////////////////////
// Memory and write-back: data memory access and the final
// register that feeds the register file
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module memory_writeback (
    input  wire                             SYS_clk,
    input  wire                             SYS_reset,
    input  wire mips_pkg::instr_t           ex_instr,
    input  wire [`MIPS_REG_ADDR_W-1:0]      ex_dest,
    input  wire                             ex_reg_write,
    input  wire                             ex_mem_read,
    input  wire                             ex_mem_write,
    input  wire [`MIPS_WORD_W-1:0]          ex_result,
    input  wire [`MIPS_WORD_W-1:0]          ex_store_data,
    output mips_pkg::instr_t                mem_instr,
    output logic [`MIPS_REG_ADDR_W-1:0]     mem_dest,
    output logic                            mem_reg_write,
    output logic                            mem_mem_read,
    output logic [`MIPS_WORD_W-1:0]         mem_alu_result,
    output logic                            wb_we,
    output logic [`MIPS_REG_ADDR_W-1:0]     wb_dest,
    output logic [`MIPS_WORD_W-1:0]         wb_data
);
    logic                           mem_mem_write;
    logic [`MIPS_WORD_W-1:0]        mem_store_data;
    logic [`MIPS_WORD_W-1:0]        dmem [`MIPS_DMEM_DEPTH];
    logic [`MIPS_DMEM_ADDR_W-1:0]   dmem_idx;
    logic [`MIPS_WORD_W-1:0]        dmem_rdata;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            mem_instr     <= '0;
            mem_dest      <= '0;
            mem_reg_write <= 1'b0;
            mem_mem_read  <= 1'b0;
            mem_mem_write <= 1'b0;
        end
        else
        begin
            mem_instr     <= ex_instr;
            mem_dest      <= ex_dest;
            mem_reg_write <= ex_reg_write;
            mem_mem_read  <= ex_mem_read;
            mem_mem_write <= ex_mem_write;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        mem_alu_result <= ex_result;
        mem_store_data <= ex_store_data;
    end

    assign dmem_idx   = mem_alu_result[`MIPS_DMEM_ADDR_W+1:2];  // word address
    assign dmem_rdata = dmem[dmem_idx];

    always_ff @(posedge SYS_clk)
    begin
        if (mem_mem_write)
            dmem[dmem_idx] <= mem_store_data;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            wb_we   <= 1'b0;
            wb_dest <= '0;
        end
        else
        begin
            wb_we   <= mem_reg_write;
            wb_dest <= mem_dest;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        wb_data <= mem_mem_read ? dmem_rdata : mem_alu_result;  // load or ALU
    end

    a_rd_wr_excl: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !(mem_mem_read && mem_mem_write));

endmodule

`default_nettype wire

// File: mips_pipeline_top.sv
////////////////////////////////////////////////////////////
// Five-stage MIPS pipeline top that wires the stages and
// the hazard unit
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module mips_pipeline_top (
    input  wire                             SYS_clk,
    input  wire                             SYS_reset,
    input  wire                             imem_load_en,
    input  wire [`MIPS_IMEM_ADDR_W-1:0]     imem_load_addr,
    input  wire [`MIPS_WORD_W-1:0]          imem_load_data,
    input  wire [`MIPS_REG_ADDR_W-1:0]      reg_sel,
    output logic [`MIPS_WORD_W-1:0]         reg_value
);
    import mips_pkg::*;

    instr_t                     fetch_instr;
    logic                       stall;
    logic                       fwd_rs;
    logic                       fwd_rt;

    instr_t                     dec_instr;
    logic [`MIPS_WORD_W-1:0]    dec_rs_val;
    logic [`MIPS_WORD_W-1:0]    dec_rt_val;
    logic [`MIPS_WORD_W-1:0]    dec_imm;
    logic [`MIPS_REG_ADDR_W-1:0] dec_dest;
    alu_op_t                    dec_alu_op;
    logic                       dec_use_imm;
    logic                       dec_reg_write;
    logic                       dec_mem_read;
    logic                       dec_mem_write;

    instr_t                     ex_instr;
    logic [`MIPS_REG_ADDR_W-1:0] ex_dest;
    logic                       ex_reg_write;
    logic                       ex_mem_read;
    logic                       ex_mem_write;
    logic [`MIPS_WORD_W-1:0]    ex_result;
    logic [`MIPS_WORD_W-1:0]    ex_store_data;

    instr_t                     mem_instr;
    logic [`MIPS_REG_ADDR_W-1:0] mem_dest;
    logic                       mem_reg_write;
    logic                       mem_mem_read;
    logic [`MIPS_WORD_W-1:0]    mem_alu_result;

    logic                       wb_we;
    logic [`MIPS_REG_ADDR_W-1:0] wb_dest;
    logic [`MIPS_WORD_W-1:0]    wb_data;

    instr_fetch      u_fetch  (.*);
    hazard_unit      u_hazard (.*);
    decode_stage     u_decode (.*);     // also holds the register file
    execute_stage    u_exec   (.*);
    memory_writeback u_mem_wb (.*);

endmodule

`default_nettype wire

// File: tb_mips_pipeline.sv
////////////////////////////////////////////////////////////
// Testbench for the five-stage MIPS pipeline that loads a
// program in reset, lets it drain and then inspects registers
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module tb_mips_pipeline;

    localparam int PROG_LEN     = 28;
    localparam int NUM_REGS     = 21;            // r0 .. r20 are checked
    localparam int RESET_CYCLES = 8;

    logic                          SYS_clk;
    logic                          SYS_reset;
    logic                          imem_load_en;
    logic [`MIPS_IMEM_ADDR_W-1:0]  imem_load_addr;
    logic [`MIPS_WORD_W-1:0]       imem_load_data;
    logic [`MIPS_REG_ADDR_W-1:0]   reg_sel;
    logic [`MIPS_WORD_W-1:0]       reg_value;

    logic [31:0]                   prog [PROG_LEN];
    logic [`MIPS_REG_ADDR_W-1:0]   exp_reg [$];
    logic [31:0]                   exp_val [$];
    logic [31:0]                   lfsr_state;
    int                            errors;
    int                            passed;

    mips_pipeline_top UUT (
        .SYS_clk        (SYS_clk),
        .SYS_reset      (SYS_reset),
        .imem_load_en   (imem_load_en),
        .imem_load_addr (imem_load_addr),
        .imem_load_data (imem_load_data),
        .reg_sel        (reg_sel),
        .reg_value      (reg_value)
    );

    initial
    begin
        SYS_clk = 1'b0;
        forever #5 SYS_clk = ~SYS_clk;
    end

    function automatic logic [31:0] rtype_word(input logic [5:0] funct, input int rs,
                                               input int rt, input int rd);
        return {`MIPS_OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input int rs,
                                               input int rt, input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [31:0] sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic logic [31:0] less_signed(input logic [31:0] a, input logic [31:0] b);
        return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endfunction

    // Galois form with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        else
            return s >> 1;
    endfunction

    task automatic draw_imm(output logic [15:0] imm);
        int i;
        imm = '0;
        for (i = 0; i < 16; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            imm = {imm[14:0], lfsr_state[0]};    // one step per bit
        end
    endtask

    task automatic build_tables();
        logic [15:0] imm_a;
        logic [15:0] imm_b;
        logic [15:0] imm_c;
        logic [31:0] e [NUM_REGS];
        int          r;
        draw_imm(imm_a);
        draw_imm(imm_b);
        draw_imm(imm_c);
        $display("addi immediates: 0x%04h 0x%04h 0x%04h", imm_a, imm_b, imm_c);

        prog[0]  = itype_word(`MIPS_OP_ADDI, 0, 1, imm_a);
        prog[1]  = itype_word(`MIPS_OP_ADDI, 0, 2, imm_b);
        prog[2]  = itype_word(`MIPS_OP_ADDI, 0, 3, imm_c);
        prog[3]  = itype_word(`MIPS_OP_ADDI, 0, 4, 16'hFED4);   // -300
        prog[4]  = rtype_word(`MIPS_FN_ADD, 1, 2, 5);           // r2 via write-through
        prog[5]  = rtype_word(`MIPS_FN_SUB, 1, 4, 6);           // r4 from memory stage
        prog[6]  = rtype_word(`MIPS_FN_AND, 5, 3, 7);
        prog[7]  = rtype_word(`MIPS_FN_OR,  6, 2, 8);
        prog[8]  = rtype_word(`MIPS_FN_SLT, 1, 4, 9);
        prog[9]  = rtype_word(`MIPS_FN_SLT, 4, 1, 10);
        prog[10] = rtype_word(`MIPS_FN_ADD, 7, 7, 11);
        prog[11] = rtype_word(`MIPS_FN_SUB, 11, 8, 12);         // execute distance stall
        prog[12] = itype_word(`MIPS_OP_ADDI, 12, 13, 16'd7);
        prog[13] = itype_word(`MIPS_OP_SW, 0, 13, 16'd8);       // stall on store data
        prog[14] = itype_word(`MIPS_OP_SW, 0, 5, 16'd12);
        prog[15] = itype_word(`MIPS_OP_ADDI, 0, 14, 16'd4);
        prog[16] = itype_word(`MIPS_OP_LW, 14, 15, 16'd4);      // word 2
        prog[17] = rtype_word(`MIPS_FN_ADD, 15, 1, 16);         // load-use costs two stalls
        prog[18] = itype_word(`MIPS_OP_LW, 0, 17, 16'd12);
        prog[19] = 32'h0;
        prog[20] = rtype_word(`MIPS_FN_OR, 17, 3, 18);          // load in memory stage
        prog[21] = itype_word(`MIPS_OP_ADDI, 1, 0, 16'd5);      // r0 target
        prog[22] = rtype_word(`MIPS_FN_ADD, 1, 2, 0);
        prog[23] = rtype_word(`MIPS_FN_ADD, 0, 1, 19);
        prog[24] = rtype_word(`MIPS_FN_SLT, 3, 3, 20);
        for (r = 25; r < PROG_LEN; r++)
            prog[r] = 32'h0;                                    // trailing nops

        // each register is written once, so a wrapped PC rewrites equal values
        e[0]  = 32'h0;
        e[1]  = sext16(imm_a);
        e[2]  = sext16(imm_b);
        e[3]  = sext16(imm_c);
        e[4]  = sext16(16'hFED4);
        e[5]  = e[1] + e[2];
        e[6]  = e[1] - e[4];
        e[7]  = e[5] & e[3];
        e[8]  = e[6] | e[2];
        e[9]  = less_signed(e[1], e[4]);
        e[10] = less_signed(e[4], e[1]);
        e[11] = e[7] + e[7];
        e[12] = e[11] - e[8];
        e[13] = e[12] + 32'd7;
        e[14] = 32'd4;
        e[15] = e[13];                                          // stored at word 2
        e[16] = e[13] + e[1];
        e[17] = e[5];                                           // stored at word 3
        e[18] = e[5] | e[3];
        e[19] = e[1];
        e[20] = 32'h0;
        for (r = 0; r < NUM_REGS; r++)
        begin
            exp_reg.push_back(5'(r));
            exp_val.push_back(e[r]);
        end
    endtask

    initial
    begin
        SYS_reset      = 1'b1;
        imem_load_en   = 1'b0;
        imem_load_addr = '0;
        imem_load_data = '0;
        reg_sel        = '0;
        lfsr_state     = 32'd65798;
        errors         = 0;
        passed         = 0;
        build_tables();

        for (int k = 0; k < PROG_LEN; k++)
        begin
            @(posedge SYS_clk);
            imem_load_en   <= 1'b1;
            imem_load_addr <= `MIPS_IMEM_ADDR_W'(k);
            imem_load_data <= prog[k];
        end
        @(posedge SYS_clk);
        imem_load_en <= 1'b0;
        repeat (RESET_CYCLES) @(posedge SYS_clk);
        SYS_reset <= 1'b0;

        repeat (3 * PROG_LEN + 10) @(posedge SYS_clk);    // pipeline drain

        for (int i = 0; i < exp_reg.size(); i++)
        begin
            @(posedge SYS_clk);
            reg_sel <= exp_reg[i];
            @(negedge SYS_clk);
            if (reg_value !== exp_val[i])
            begin
                errors++;
                $display("** Error: reg_value for r%0d expected 0x%08h got 0x%08h",
                         exp_reg[i], exp_val[i], reg_value);
            end
            else
            begin
                passed++;
                $display("ok: r%0d = 0x%08h", exp_reg[i], reg_value);
            end
        end

        $display("checks: %0d run, %0d passed, %0d failed", exp_reg.size(), passed, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    // bounded by load, drain and check time
    initial
    begin
        repeat (4 * PROG_LEN + 50) @(posedge SYS_clk);
        $display("watchdog: the run timed out before all registers were checked");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
mips_pkg.sv
instr_fetch.sv
hazard_unit.sv
decode_stage.sv
execute_stage.sv
memory_writeback.sv
mips_pipeline_top.sv
tb_mips_pipeline.sv
